//--- Bender.yml
package:
  name: conv_layer

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cim_pkg.sv
      - logic/window_loader.sv
      - crossbar/cim_tile_array.sv
      - logic/conv_func.sv
      - logic/ofmap_buffer.sv
      - logic/conv_layer_top.sv
  - target: test
    include_dirs:
      - common
      - verification
    files:
      - verification/conv_layer_tb.sv

//--- common/cim_defs.svh
`ifndef CIM_DEFS_SVH
`define CIM_DEFS_SVH

// Layer geometry
`define CIM_DATA_SIZE       8
`define CIM_INPUT_CHANNELS  2
`define CIM_KERNEL_DIM      3
`define CIM_WINDOW_LEN      (`CIM_INPUT_CHANNELS * `CIM_KERNEL_DIM * `CIM_KERNEL_DIM)
`define CIM_OUTPUT_CHANNELS 4

// Crossbar tiling, rows and columns counted in bits
`define CIM_XBAR_SIZE       16
`define CIM_V_TILES         ((`CIM_WINDOW_LEN + `CIM_XBAR_SIZE - 1) / `CIM_XBAR_SIZE)
`define CIM_H_TILES \
    ((`CIM_OUTPUT_CHANNELS * `CIM_DATA_SIZE + `CIM_XBAR_SIZE - 1) / `CIM_XBAR_SIZE)
`define CIM_ELEMS_PER_TILE  (`CIM_XBAR_SIZE / `CIM_DATA_SIZE)

// Output buffer layout
`define CIM_OBUF_DATA_SIZE  (2 * `CIM_DATA_SIZE + $clog2(`CIM_XBAR_SIZE))
`define CIM_OBUF_BUS_WIDTH  20
`define CIM_NUM_CHANNELS    (`CIM_OBUF_BUS_WIDTH / `CIM_OBUF_DATA_SIZE)
`define CIM_NUM_ADDR \
    ((`CIM_ELEMS_PER_TILE + `CIM_NUM_CHANNELS - 1) / `CIM_NUM_CHANNELS)
`define CIM_ADDR_W          ((`CIM_NUM_ADDR > 1) ? $clog2(`CIM_NUM_ADDR) : 1)

// Weight port index widths
`define CIM_CHAN_W          ($clog2(`CIM_OUTPUT_CHANNELS))
`define CIM_IDX_W           ($clog2(`CIM_WINDOW_LEN))

`endif

//--- common/cim_pkg.sv
`default_nettype none

`include "cim_defs.svh"

package cim_pkg;

    // Input activation, unsigned
    typedef logic [`CIM_DATA_SIZE-1:0] act_t;

    // Crossbar weight, two's complement
    typedef logic signed [`CIM_DATA_SIZE-1:0] wt_t;

    // One crossbar column result
    typedef logic signed [`CIM_OBUF_DATA_SIZE-1:0] psum_t;

    typedef enum logic {
        conv_func_idle, // Waiting for a result
        conv_func_busy  // Walking the buffer
    } conv_func_state_t;

    typedef enum logic [1:0] {
        xbar_idle,    // Ready for a window
        xbar_compute, // One vertical tile per cycle
        xbar_hold     // Result waits for readout
    } xbar_state_t;

endpackage

`default_nettype wire

//--- crossbar/cim_tile_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cim_defs.svh"

module cim_tile_array (
    input  wire                     clk,
    input  wire                     rst,

    // Window from the loader
    input  wire                     i_win_start,
    input  wire cim_pkg::act_t      i_window [`CIM_WINDOW_LEN-1:0],
    output logic                    o_xbar_ready,

    // Weight write port
    input  wire                     i_wt_we,
    input  wire [`CIM_CHAN_W-1:0]   i_wt_chan,
    input  wire [`CIM_IDX_W-1:0]    i_wt_idx,
    input  wire cim_pkg::wt_t       i_wt_data,

    // Readout side
    input  wire [`CIM_ADDR_W-1:0]   i_addr,
    input  wire                     i_func_ready,
    output logic                    o_cim_ready,
    output logic                    o_result_valid,
    output cim_pkg::psum_t          o_psum [`CIM_H_TILES-1:0][`CIM_NUM_CHANNELS-1:0]
                                           [`CIM_V_TILES-1:0]
);

    localparam int WIN_LEN  = `CIM_WINDOW_LEN;
    localparam int OUT_CH   = `CIM_OUTPUT_CHANNELS;
    localparam int XBAR     = `CIM_XBAR_SIZE;
    localparam int H_TILES  = `CIM_H_TILES;
    localparam int V_TILES  = `CIM_V_TILES;
    localparam int NUM_CH   = `CIM_NUM_CHANNELS;
    localparam int NUM_ADDR = `CIM_NUM_ADDR;
    localparam int VT_W     = (V_TILES > 1) ? $clog2(V_TILES) : 1;

    localparam logic [VT_W-1:0] LAST_VT = VT_W'(V_TILES - 1);

    cim_pkg::xbar_state_t state;
    logic [VT_W-1:0]      vt;                       // Tile being computed
    cim_pkg::wt_t         wt_mem [OUT_CH-1:0][WIN_LEN-1:0];
    cim_pkg::act_t        win_q [WIN_LEN-1:0];
    cim_pkg::psum_t       dot [OUT_CH-1:0];         // Current tile, per channel
    cim_pkg::psum_t       obuf [NUM_ADDR-1:0][H_TILES-1:0][NUM_CH-1:0][V_TILES-1:0];

    // Activation is zero-extended, weight sign-extended
    function automatic cim_pkg::psum_t mul_term(input cim_pkg::act_t a, input cim_pkg::wt_t w);
        cim_pkg::psum_t pa;
        cim_pkg::psum_t pw;
        pa = cim_pkg::psum_t'({1'b0, a});
        pw = cim_pkg::psum_t'(w);
        return pa * pw;
    endfunction

    assign o_xbar_ready   = (state == cim_pkg::xbar_idle);
    assign o_cim_ready    = (state != cim_pkg::xbar_compute);
    assign o_result_valid = (state == cim_pkg::xbar_hold);
    assign o_psum         = obuf[i_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cim_pkg::xbar_idle;
            vt    <= '0;
        end else begin
            case (state)
                cim_pkg::xbar_idle: begin
                    if (i_win_start) begin
                        state <= cim_pkg::xbar_compute;
                        vt    <= '0;
                    end
                end
                cim_pkg::xbar_compute: begin
                    if (vt == LAST_VT) begin
                        state <= cim_pkg::xbar_hold;
                    end else begin
                        vt <= vt + 1'b1;
                    end
                end
                cim_pkg::xbar_hold: begin
                    if (!i_func_ready) begin
                        state <= cim_pkg::xbar_idle; // Readout has started
                    end
                end
                default: state <= cim_pkg::xbar_idle;
            endcase
        end
    end

    // Weights only change while no window is in the array
    always_ff @(posedge clk) begin
        if (i_wt_we && state == cim_pkg::xbar_idle &&
            int'(i_wt_chan) < OUT_CH && int'(i_wt_idx) < WIN_LEN) begin
            wt_mem[i_wt_chan][i_wt_idx] <= i_wt_data;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cim_pkg::xbar_idle && i_win_start) begin
            win_q <= i_window;
        end
    end

    // Rows past the window end act as zero padding
    always_comb begin
        int base;
        base = int'(vt) * XBAR;
        for (int c = 0; c < OUT_CH; c++) begin
            dot[c] = '0;
            for (int r = 0; r < XBAR; r++) begin
                if (base + r < WIN_LEN) begin
                    dot[c] = dot[c] + mul_term(win_q[base + r], wt_mem[c][base + r]);
                end
            end
        end
    end

    // Channel c lands at address a, tile h, element j
    always_ff @(posedge clk) begin
        if (state == cim_pkg::xbar_compute) begin
            for (int a = 0; a < NUM_ADDR; a++) begin
                for (int h = 0; h < H_TILES; h++) begin
                    for (int j = 0; j < NUM_CH; j++) begin
                        if (a * H_TILES * NUM_CH + h * NUM_CH + j < OUT_CH) begin
                            obuf[a][h][j][vt] <= dot[a * H_TILES * NUM_CH + h * NUM_CH + j];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/conv_func.sv
`timescale 1ns/1ps
`default_nettype none

`include "cim_defs.svh"

module conv_func (
    input  wire                              clk,
    input  wire                              rst,

    // Crossbar handshake
    input  wire                              i_start,
    output logic                             o_ready,
    input  wire                              i_cim_ready,
    input  wire cim_pkg::psum_t              i_data [`CIM_H_TILES-1:0][`CIM_NUM_CHANNELS-1:0]
                                                    [`CIM_V_TILES-1:0],
    output logic [`CIM_ADDR_W-1:0]           o_addr,

    // Output map side
    input  wire                              i_next_ready,
    output cim_pkg::act_t                    o_data [`CIM_OUTPUT_CHANNELS-1:0],
    output logic [`CIM_OUTPUT_CHANNELS-1:0]  o_write_enable,
    output logic                             o_start
);

    localparam int DATA_SIZE = `CIM_DATA_SIZE;
    localparam int OUT_CH    = `CIM_OUTPUT_CHANNELS;
    localparam int H_TILES   = `CIM_H_TILES;
    localparam int V_TILES   = `CIM_V_TILES;
    localparam int NUM_CH    = `CIM_NUM_CHANNELS;
    localparam int NUM_ADDR  = `CIM_NUM_ADDR;
    localparam int ADDR_W    = `CIM_ADDR_W;
    localparam int GRP       = H_TILES * NUM_CH;                     // Channels per address
    localparam int ACC_W     = `CIM_OBUF_DATA_SIZE + $clog2(V_TILES); // Room for the tile sum

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(NUM_ADDR - 1);
    localparam logic [OUT_CH-1:0] FIRST_WE  = OUT_CH'((1 << GRP) - 1);

    cim_pkg::conv_func_state_t state;
    cim_pkg::conv_func_state_t next_state;
    logic [ADDR_W-1:0]         addr;
    logic [ADDR_W-1:0]         next_addr;
    logic [OUT_CH-1:0]         next_we;
    logic signed [ACC_W-1:0]   acc [H_TILES-1:0][NUM_CH-1:0];
    cim_pkg::act_t             relu_val [GRP-1:0];

    assign o_addr = addr;

    // Vertical tile sum, then ReLU and keep the low byte
    always_comb begin
        for (int h = 0; h < H_TILES; h++) begin
            for (int j = 0; j < NUM_CH; j++) begin
                acc[h][j] = '0;
                for (int v = 0; v < V_TILES; v++) begin
                    acc[h][j] = acc[h][j] + ACC_W'(i_data[h][j][v]);
                end
                if (acc[h][j][ACC_W-1]) begin
                    relu_val[h * NUM_CH + j] = '0; // Negative sum
                end else begin
                    relu_val[h * NUM_CH + j] = acc[h][j][DATA_SIZE-1:0];
                end
            end
        end
    end

    // Every address group sees the same values; write enable picks the slot
    always_comb begin
        for (int c = 0; c < OUT_CH; c++) begin
            o_data[c] = relu_val[c % GRP];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= cim_pkg::conv_func_idle;
            addr           <= '0;
            o_write_enable <= '0;
        end else begin
            state          <= next_state;
            addr           <= next_addr;
            o_write_enable <= next_we;
        end
    end

    always_comb begin
        next_state = state;
        next_addr  = addr;
        next_we    = o_write_enable;
        o_ready    = 1'b0;
        o_start    = 1'b0;
        case (state)
            cim_pkg::conv_func_idle: begin
                o_ready   = 1'b1;
                next_addr = '0;
                next_we   = '0;
                if (i_start && i_cim_ready && i_next_ready) begin
                    next_state = cim_pkg::conv_func_busy;
                    next_we    = FIRST_WE; // First address group
                end
            end
            cim_pkg::conv_func_busy: begin
                if (addr == LAST_ADDR) begin
                    next_state = cim_pkg::conv_func_idle;
                    next_addr  = '0;
                    next_we    = '0;
                    o_start    = 1'b1; // Vector complete
                end else begin
                    next_addr = addr + 1'b1;
                    next_we   = o_write_enable << GRP;
                end
            end
            default: begin
                next_state = cim_pkg::conv_func_idle;
                next_addr  = '0;
                next_we    = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/conv_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cim_defs.svh"

module conv_layer_top (
    input  wire                           clk,
    input  wire                           rst,

    input  wire                           i_act_valid,
    input  wire cim_pkg::act_t            i_act_data,
    output wire                           o_act_ready,

    input  wire                           i_wt_we,
    input  wire [`CIM_CHAN_W-1:0]         i_wt_chan,
    input  wire [`CIM_IDX_W-1:0]          i_wt_idx,
    input  wire cim_pkg::wt_t             i_wt_data,

    output wire                           o_out_valid,
    output wire cim_pkg::act_t            o_out_data [`CIM_OUTPUT_CHANNELS-1:0],
    input  wire                           i_out_ready
);

    wire                          win_start;
    wire                          xbar_ready;
    wire cim_pkg::act_t           window [`CIM_WINDOW_LEN-1:0];
    wire                          cim_ready;
    wire                          result_valid;
    wire                          func_ready;
    wire [`CIM_ADDR_W-1:0]        obuf_addr;
    wire cim_pkg::psum_t          psum [`CIM_H_TILES-1:0][`CIM_NUM_CHANNELS-1:0]
                                       [`CIM_V_TILES-1:0];
    wire cim_pkg::act_t           func_data [`CIM_OUTPUT_CHANNELS-1:0];
    wire [`CIM_OUTPUT_CHANNELS-1:0] func_we;
    wire                          func_start;
    wire                          next_ready;

    window_loader window_loader_inst (
        .clk          (clk),
        .rst          (rst),
        .i_act_valid  (i_act_valid),
        .i_act_data   (i_act_data),
        .o_act_ready  (o_act_ready),
        .i_xbar_ready (xbar_ready),
        .o_win_start  (win_start),
        .o_window     (window)
    );

    cim_tile_array cim_tile_array_inst (
        .clk            (clk),
        .rst            (rst),
        .i_win_start    (win_start),
        .i_window       (window),
        .o_xbar_ready   (xbar_ready),
        .i_wt_we        (i_wt_we),
        .i_wt_chan      (i_wt_chan),
        .i_wt_idx       (i_wt_idx),
        .i_wt_data      (i_wt_data),
        .i_addr         (obuf_addr),
        .i_func_ready   (func_ready),
        .o_cim_ready    (cim_ready),
        .o_result_valid (result_valid),
        .o_psum         (psum)
    );

    conv_func conv_func_inst (
        .clk            (clk),
        .rst            (rst),
        .i_start        (result_valid), // Hold state means a result is ready
        .o_ready        (func_ready),
        .i_cim_ready    (cim_ready),
        .i_data         (psum),
        .o_addr         (obuf_addr),
        .i_next_ready   (next_ready),
        .o_data         (func_data),
        .o_write_enable (func_we),
        .o_start        (func_start)
    );

    ofmap_buffer ofmap_buffer_inst (
        .clk            (clk),
        .rst            (rst),
        .i_data         (func_data),
        .i_write_enable (func_we),
        .i_start        (func_start),
        .o_next_ready   (next_ready),
        .o_out_valid    (o_out_valid),
        .o_out_data     (o_out_data),
        .i_out_ready    (i_out_ready)
    );

endmodule

`default_nettype wire

//--- logic/ofmap_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cim_defs.svh"

module ofmap_buffer (
    input  wire                             clk,
    input  wire                             rst,

    // From the readout stage
    input  wire cim_pkg::act_t              i_data [`CIM_OUTPUT_CHANNELS-1:0],
    input  wire [`CIM_OUTPUT_CHANNELS-1:0]  i_write_enable,
    input  wire                             i_start,
    output logic                            o_next_ready,

    // Output stream
    output logic                            o_out_valid,
    output cim_pkg::act_t                   o_out_data [`CIM_OUTPUT_CHANNELS-1:0],
    input  wire                             i_out_ready
);

    localparam int OUT_CH = `CIM_OUTPUT_CHANNELS;

    cim_pkg::act_t vec_q [OUT_CH-1:0]; // One slot per output channel
    logic          full;               // Vector waiting downstream

    assign o_next_ready = !full;
    assign o_out_valid  = full;
    assign o_out_data   = vec_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (i_start) begin
            full <= 1'b1; // Last group lands on this edge
        end else if (full && i_out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < OUT_CH; c++) begin
            if (i_write_enable[c]) begin
                vec_q[c] <= i_data[c];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/window_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "cim_defs.svh"

module window_loader (
    input  wire                clk,
    input  wire                rst,

    // Activation stream
    input  wire                i_act_valid,
    input  wire cim_pkg::act_t i_act_data,
    output logic               o_act_ready,

    // Crossbar side
    input  wire                i_xbar_ready,
    output logic               o_win_start,
    output cim_pkg::act_t      o_window [`CIM_WINDOW_LEN-1:0]
);

    localparam int WIN_LEN = `CIM_WINDOW_LEN;
    localparam int CNT_W   = $clog2(WIN_LEN + 1);

    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(WIN_LEN);

    cim_pkg::act_t    win_q [WIN_LEN-1:0]; // Window register file
    logic [CNT_W-1:0] fill_cnt;            // Values held so far
    logic             full;
    logic             act_fire;
    logic             win_fire;

    assign full     = (fill_cnt == FULL_CNT);
    assign act_fire = i_act_valid && !full; // Ready is low once full
    assign win_fire = full && i_xbar_ready;

    assign o_act_ready = !full;
    assign o_win_start = full;
    assign o_window    = win_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt <= '0;
        end else if (win_fire) begin
            fill_cnt <= '0; // Crossbar latched the window
        end else if (act_fire) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // Window fills in index order, 0 first
    always_ff @(posedge clk) begin
        if (act_fire) begin
            win_q[fill_cnt] <= i_act_data;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
+incdir+verification
common/cim_pkg.sv
logic/window_loader.sv
crossbar/cim_tile_array.sv
logic/conv_func.sv
logic/ofmap_buffer.sv
logic/conv_layer_top.sv
verification/conv_layer_tb.sv

//--- verification/conv_layer_tasks.svh
`ifndef CONV_LAYER_TASKS_SVH
`define CONV_LAYER_TASKS_SVH

// Tasks are entered and left just after a rising edge

task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, got);
    end
endtask

task automatic check_done(input logic ok, input string what);
    checks++;
    assert (ok) else begin
        errors++;
        $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    end
endtask

task automatic load_weights();
    for (int c = 0; c < OUT_CH; c++) begin
        for (int i = 0; i < WIN_LEN; i++) begin
            wt_we   <= 1'b1;
            wt_chan <= CHAN_W'(c);
            wt_idx  <= IDX_W'(i);
            wt_data <= wt_model[c][i];
            @(posedge clk); // Write lands on this edge
        end
    end
    wt_we <= 1'b0;
endtask

task automatic queue_window();
    for (int i = 0; i < WIN_LEN; i++) begin
        act_q.push_back(win_buf[i]);
    end
    exp_q.push_back(model_vector());
endtask

task automatic send_acts();
    int wait_cycles;
    while (act_q.size() > 0) begin
        act_valid <= 1'b1;
        act_data  <= act_q.pop_front();
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!act_ready && wait_cycles < WAIT_LIMIT);
        check_done(act_ready, "o_act_ready to take an activation");
        if (!act_ready) begin
            act_q.delete();
        end
    end
    act_valid <= 1'b0;
endtask

task automatic collect_vectors(input int count);
    logic [DW*OUT_CH-1:0] exp_vec;
    int                   wait_cycles;
    for (int n = 0; n < count; n++) begin
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!(out_valid && out_ready) && wait_cycles < WAIT_LIMIT);
        check_done(out_valid && out_ready, "an output vector on o_out_valid");
        if (!(out_valid && out_ready)) begin
            exp_q.delete();
            return;
        end
        exp_vec = exp_q.pop_front();
        for (int c = 0; c < OUT_CH; c++) begin
            check_equal($sformatf("o_out_data[%0d]", c), 32'(out_data[c]),
                        32'(exp_vec[DW*c +: DW]));
        end
    end
endtask

task automatic test_reset_state();
    check_equal("o_act_ready", 32'(act_ready), 32'h1);
    check_equal("o_out_valid", 32'(out_valid), 32'h0);
endtask

// Channel c passes activation c through, covering both tiles and addresses
task automatic test_identity();
    for (int c = 0; c < OUT_CH; c++) begin
        for (int i = 0; i < WIN_LEN; i++) begin
            wt_model[c][i] = (i == c) ? cim_pkg::wt_t'(1) : cim_pkg::wt_t'(0);
        end
    end
    load_weights();
    for (int i = 0; i < WIN_LEN; i++) begin
        win_buf[i] = cim_pkg::act_t'(i * 37 + 11);
    end
    queue_window();
    send_acts();
    collect_vectors(1);
endtask

task automatic test_relu_trunc();
    for (int c = 0; c < OUT_CH; c++) begin
        for (int i = 0; i < WIN_LEN; i++) begin
            wt_model[c][i] = '0;
        end
    end
    for (int i = 0; i < WIN_LEN; i++) begin
        wt_model[2][i] = cim_pkg::wt_t'(3);                       // Wraps past 255
        wt_model[3][i] = (i < 16) ? cim_pkg::wt_t'(-5) : cim_pkg::wt_t'(50);
        win_buf[i]     = cim_pkg::act_t'(200);
    end
    wt_model[0][16] = cim_pkg::wt_t'(-128); // Negative only from the second tile
    wt_model[0][17] = cim_pkg::wt_t'(-128);
    wt_model[1][0]  = cim_pkg::wt_t'(127);
    wt_model[1][16] = cim_pkg::wt_t'(127);
    wt_model[1][17] = cim_pkg::wt_t'(127);
    load_weights();
    queue_window();
    send_acts();
    collect_vectors(1);
endtask

task automatic test_random_stream();
    for (int c = 0; c < OUT_CH; c++) begin
        for (int i = 0; i < WIN_LEN; i++) begin
            wt_model[c][i] = cim_pkg::wt_t'(lfsr_byte());
        end
    end
    load_weights();
    repeat (8) begin
        for (int i = 0; i < WIN_LEN; i++) begin
            win_buf[i] = lfsr_byte();
        end
        queue_window();
    end
    fork
        send_acts();
        collect_vectors(8);
    join
endtask

// Three windows fill the loader, crossbar and output buffer
task automatic test_back_pressure();
    out_ready <= 1'b0;
    repeat (3) begin
        for (int i = 0; i < WIN_LEN; i++) begin
            win_buf[i] = lfsr_byte();
        end
        queue_window();
    end
    send_acts();
    repeat (10) @(posedge clk);
    check_equal("o_act_ready", 32'(act_ready), 32'h0);
    check_equal("o_out_valid", 32'(out_valid), 32'h1);
    out_ready <= 1'b1;
    collect_vectors(3);
endtask

`endif

//--- verification/conv_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cim_defs.svh"

module conv_layer_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int DW            = `CIM_DATA_SIZE;
    localparam int OUT_CH        = `CIM_OUTPUT_CHANNELS;
    localparam int WIN_LEN       = `CIM_WINDOW_LEN;
    localparam int CHAN_W        = `CIM_CHAN_W;
    localparam int IDX_W         = `CIM_IDX_W;
    localparam int NUM_WINDOWS   = 13;  // 1 + 1 + 8 + 3 windows over all tests
    localparam int WINDOW_CYCLES = 200; // Per-window bound, weight loads included
    localparam int WAIT_LIMIT    = 100; // Longest wait for one handshake

    logic                  clk;
    logic                  rst;
    logic                  act_valid;
    cim_pkg::act_t         act_data;
    wire                   act_ready;
    logic                  wt_we;
    logic [CHAN_W-1:0]     wt_chan;
    logic [IDX_W-1:0]      wt_idx;
    cim_pkg::wt_t          wt_data;
    wire                   out_valid;
    wire cim_pkg::act_t    out_data [OUT_CH-1:0];
    logic                  out_ready;

    logic [31:0]           lfsr;
    int                    errors;
    int                    checks;
    cim_pkg::wt_t          wt_model [OUT_CH][WIN_LEN]; // Weights the DUT should hold
    cim_pkg::act_t         win_buf [WIN_LEN];          // Window being prepared
    cim_pkg::act_t         act_q [$];                  // Activations still to send
    logic [DW*OUT_CH-1:0]  exp_q [$];                  // Expected vectors in order

    conv_layer_top conv_layer_top_inst (
        .clk         (clk),
        .rst         (rst),
        .i_act_valid (act_valid),
        .i_act_data  (act_data),
        .o_act_ready (act_ready),
        .i_wt_we     (wt_we),
        .i_wt_chan   (wt_chan),
        .i_wt_idx    (wt_idx),
        .i_wt_data   (wt_data),
        .o_out_valid (out_valid),
        .o_out_data  (out_data),
        .i_out_ready (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [DW-1:0] lfsr_byte();
        logic [DW-1:0] b;
        b = '0;
        for (int i = 0; i < DW; i++) begin
            b = {b[DW-2:0], lfsr_step()};
        end
        return b;
    endfunction

    // Exact signed dot product per channel, then ReLU and the low byte
    function automatic logic [DW*OUT_CH-1:0] model_vector();
        logic [DW*OUT_CH-1:0] vec;
        int                   sum;
        vec = '0;
        for (int c = 0; c < OUT_CH; c++) begin
            sum = 0;
            for (int i = 0; i < WIN_LEN; i++) begin
                sum += int'(win_buf[i]) * int'(wt_model[c][i]);
            end
            vec[DW*c +: DW] = (sum < 0) ? '0 : sum[DW-1:0];
        end
        return vec;
    endfunction

    `include "conv_layer_tasks.svh"

    initial begin
        #(NUM_WINDOWS * WINDOW_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished, errors so far: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        act_valid = 1'b0;
        act_data  = '0;
        wt_we     = 1'b0;
        wt_chan   = '0;
        wt_idx    = '0;
        wt_data   = '0;
        out_ready = 1'b1;
        lfsr      = 32'h8fad_ede4;
        errors    = 0;
        checks    = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_identity();
        test_relu_trunc();
        test_random_stream();
        test_back_pressure();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
